// File: include/vldu_consts.svh
// Vector load unit constants
// Lane organization, field widths and queue depths
`ifndef VLDU_CONSTS_SVH
`define VLDU_CONSTS_SVH

// Lane organization
`define VLDU_NR_LANES 4
// One lane word and one memory beat are the same size
`define VLDU_LANE_BYTES 8
// Full register-file word across all lanes
`define VLDU_WORD_BYTES 32

// Queue depths, both powers of two
`define VLDU_INSN_DEPTH 4
`define VLDU_RESULT_DEPTH 2

// Instruction fields
`define VLDU_VL_WIDTH 10
`define VLDU_ID_WIDTH 3
`define VLDU_VD_WIDTH 5

// Register-file addressing
`define VLDU_ADDR_WIDTH 12
`define VLDU_REG_WORDS 32

`endif

// File: hw/vldu_pkg.sv
// Vector load unit types
// Element widths, instruction fields and the per-lane write payload
`default_nettype none
`include "vldu_consts.svh"

package vldu_pkg;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  typedef logic [`VLDU_ID_WIDTH-1:0] vid_t;
  typedef logic [`VLDU_VD_WIDTH-1:0] vreg_t;
  typedef logic [`VLDU_VL_WIDTH-1:0] vl_t;
  // Max vl shifted by max sew needs three extra bits
  typedef logic [`VLDU_VL_WIDTH+2:0] vlen_t;

  typedef logic [`VLDU_LANE_BYTES*8-1:0] lane_data_t;
  typedef logic [`VLDU_LANE_BYTES-1:0] lane_be_t;
  typedef logic [`VLDU_ADDR_WIDTH-1:0] vaddr_t;

  // Load instruction as stored in the queue
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vl_t   vl;
    sew_e  sew;
  } ldu_insn_t;

  // Write request payload of one lane
  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    lane_data_t data;
    lane_be_t   be;
  } lane_result_t;

  // Bytes moved by one instruction, vl scaled by element size
  function automatic vlen_t insn_bytes(ldu_insn_t insn);
    return vlen_t'(insn.vl) << insn.sew;
  endfunction

endpackage
`default_nettype wire

// File: hw/vldu_insn_if.sv
// Issue and commit link of the vector load unit
// Carries the issuing instruction to the packer, the committing
// instruction's id, and the issue/pop events back to the queue
`timescale 1ns/10ps
`default_nettype none

interface vldu_insn_if import vldu_pkg::*; ();

  // Instruction currently issued to the packer
  logic      issue_valid;
  ldu_insn_t issue_insn;

  // Oldest instruction still waiting for its words to drain
  logic commit_valid;
  vid_t commit_id;

  // Pulse when the issuing instruction's last word is pushed
  logic issue_done;
  // Pulse when a word has been granted by every lane
  logic word_popped;

  modport insn_queue (
    output issue_valid,
    output issue_insn,
    output commit_valid,
    output commit_id,
    input  issue_done,
    input  word_popped
  );

  modport packer (
    input  issue_valid,
    input  issue_insn,
    output issue_done
  );

  modport result (
    output word_popped
  );

endinterface
`default_nettype wire

// File: hw/vldu_insn_queue.sv
// Vector load instruction queue
// Holds up to four loads between acceptance and commit, tracks the
// remaining commit bytes and raises the registered completion pulse
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_insn_queue import vldu_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Sequencer request
  input  wire logic       req_valid_i,
  input  wire ldu_insn_t  req_insn_i,
  output logic            req_ready_o,
  // Link to packer and result queue
  vldu_insn_if.insn_queue insn,
  // Completion report
  output logic            load_complete_o,
  output vid_t            done_id_o
);

  localparam int unsigned Depth     = `VLDU_INSN_DEPTH;
  localparam int unsigned PntW      = $clog2(Depth);
  localparam int unsigned WordBytes = `VLDU_WORD_BYTES;

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [PntW:0]   cnt_t;

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  ldu_insn_t insn_q [Depth];

  // Pointers wrap naturally, depth is a power of two
  pnt_t accept_pnt_q;
  pnt_t issue_pnt_q;
  pnt_t commit_pnt_q;
  pnt_t next_commit_pnt;
  // Entries not yet issued, and not yet committed
  cnt_t issue_cnt_q;
  cnt_t commit_cnt_q;

  // Bytes of the committing instruction still in flight
  vlen_t commit_bytes_q;
  vlen_t commit_bytes_d;

  logic accept;
  logic retire;

  // Full once four loads are uncommitted
  assign req_ready_o = (commit_cnt_q != cnt_t'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign insn.issue_valid  = (issue_cnt_q != '0);
  assign insn.issue_insn   = insn_q[issue_pnt_q];
  assign insn.commit_valid = (commit_cnt_q != '0);
  assign insn.commit_id    = insn_q[commit_pnt_q].id;

  assign next_commit_pnt = commit_pnt_q + 1'b1;

  //////////////////////////////////////////////////
  // Commit byte counting
  //////////////////////////////////////////////////

  always_comb begin
    commit_bytes_d = commit_bytes_q;
    retire         = 1'b0;

    // One full word leaves per pop, the tail word may be partial
    if (insn.word_popped) begin
      if (commit_bytes_q > vlen_t'(WordBytes)) begin
        commit_bytes_d = commit_bytes_q - vlen_t'(WordBytes);
      end else begin
        commit_bytes_d = '0;
        retire         = insn.commit_valid;
      end
    end

    // Load the byte count of the next instruction to commit
    if (retire && (commit_cnt_q > cnt_t'(1))) begin
      commit_bytes_d = insn_bytes(insn_q[next_commit_pnt]);
    end else if (accept && ((commit_cnt_q == '0) || (retire && commit_cnt_q == cnt_t'(1)))) begin
      // Queue drains empty, the new request is next in line
      commit_bytes_d = insn_bytes(req_insn_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q    <= '0;
      issue_pnt_q     <= '0;
      commit_pnt_q    <= '0;
      issue_cnt_q     <= '0;
      commit_cnt_q    <= '0;
      commit_bytes_q  <= '0;
      load_complete_o <= 1'b0;
      done_id_o       <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      // Last word pushed, move on to the next instruction
      if (insn.issue_done) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (retire) begin
        commit_pnt_q <= next_commit_pnt;
        done_id_o    <= insn.commit_id;
      end
      issue_cnt_q     <= issue_cnt_q + cnt_t'(accept) - cnt_t'(insn.issue_done);
      commit_cnt_q    <= commit_cnt_q + cnt_t'(accept) - cnt_t'(retire);
      commit_bytes_q  <= commit_bytes_d;
      // Pulse one cycle after the last word's pop
      load_complete_o <= retire;
    end
  end

  // Instruction payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= req_insn_i;
    end
  end

endmodule
`default_nettype wire

// File: hw/vldu_beat_packer.sv
// Vector load beat packer
// Copies each 64-bit memory beat into the next lane of a register word,
// masks bytes past the instruction end and pushes finished words
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_beat_packer import vldu_pkg::*; (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  // Memory read beats
  input  wire logic          r_valid_i,
  input  wire lane_data_t    r_data_i,
  output logic               r_ready_o,
  // Issuing instruction
  vldu_insn_if.packer        insn,
  // Word push into the result queue
  input  wire logic          full_i,
  output logic               push_valid_o,
  output lane_result_t [`VLDU_NR_LANES-1:0] push_word_o
);

  localparam int unsigned NrLanes   = `VLDU_NR_LANES;
  localparam int unsigned LaneBytes = `VLDU_LANE_BYTES;
  localparam int unsigned WordBytes = `VLDU_WORD_BYTES;
  // Byte offset fields inside the instruction's byte count
  localparam int unsigned LaneOffW  = $clog2(LaneBytes);
  localparam int unsigned WordOffW  = $clog2(WordBytes);
  localparam int unsigned LanePntW  = WordOffW - LaneOffW;

  //////////////////////////////////////////////////
  // Issue byte count
  //////////////////////////////////////////////////

  // Bytes of the issuing instruction already taken from memory
  vlen_t issue_off_q;
  vlen_t issue_total;
  vlen_t issue_left;

  // Lane filled by the current beat
  logic [LanePntW-1:0] lane_pnt;
  vaddr_t word_idx;
  vaddr_t word_addr;

  logic beat_fire;
  logic last_beat;
  logic last_lane;
  lane_be_t beat_be;

  // Lanes already filled in the word being assembled
  lane_data_t data_q [NrLanes];
  lane_be_t   be_q [NrLanes];

  assign issue_total = insn_bytes(insn.issue_insn);
  assign issue_left  = issue_total - issue_off_q;

  // Sequential fill, so the lane and word index come straight from the offset
  assign lane_pnt  = issue_off_q[WordOffW-1:LaneOffW];
  assign word_idx  = vaddr_t'(issue_off_q >> WordOffW);
  assign word_addr = vaddr_t'(insn.issue_insn.vd * `VLDU_REG_WORDS) + word_idx;

  assign last_beat = (issue_left <= vlen_t'(LaneBytes));
  assign last_lane = (lane_pnt == LanePntW'(NrLanes - 1));

  // Accept beats only with an instruction and room for a word
  assign r_ready_o = insn.issue_valid && !full_i;
  assign beat_fire = r_valid_i && r_ready_o;

  // Word leaves on its last lane or on the instruction's tail
  assign push_valid_o    = beat_fire && (last_lane || last_beat);
  assign insn.issue_done = beat_fire && last_beat;

  // Enable only the bytes still inside the instruction
  always_comb begin
    for (int b = 0; b < LaneBytes; b++) begin
      beat_be[b] = (vlen_t'(b) < issue_left);
    end
  end

  //////////////////////////////////////////////////
  // Word assembly
  //////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < NrLanes; k++) begin
      push_word_o[k].id   = insn.issue_insn.id;
      push_word_o[k].addr = word_addr;
      if (k < lane_pnt) begin
        push_word_o[k].data = data_q[k];
        push_word_o[k].be   = be_q[k];
      end else if (k == lane_pnt) begin
        // Current beat goes straight into the pushed word
        push_word_o[k].data = r_data_i;
        push_word_o[k].be   = beat_be;
      end else begin
        // Lanes past the tail carry no enables
        push_word_o[k].data = '0;
        push_word_o[k].be   = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_off_q <= '0;
    end else if (beat_fire) begin
      // Next instruction starts on a fresh beat at lane 0
      if (last_beat) begin
        issue_off_q <= '0;
      end else begin
        issue_off_q <= issue_off_q + vlen_t'(LaneBytes);
      end
    end
  end

  // Lane payload
  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      data_q[lane_pnt] <= r_data_i;
      be_q[lane_pnt]   <= beat_be;
    end
  end

endmodule
`default_nettype wire

// File: hw/vldu_result_queue.sv
// Vector load result queue
// Two register words waiting for the lanes, each lane drained on its
// own request/grant handshake, the word pops once all lanes are done
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_result_queue import vldu_pkg::*; (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  // Word push from the packer
  input  wire logic                                push_valid_i,
  input  wire lane_result_t [`VLDU_NR_LANES-1:0]  push_word_i,
  output logic                                     full_o,
  // Pop event to the instruction queue
  vldu_insn_if.result                              insn,
  // Lane write ports
  output logic         [`VLDU_NR_LANES-1:0]        result_req_o,
  output vid_t         [`VLDU_NR_LANES-1:0]        result_id_o,
  output vaddr_t       [`VLDU_NR_LANES-1:0]        result_addr_o,
  output lane_data_t   [`VLDU_NR_LANES-1:0]        result_wdata_o,
  output lane_be_t     [`VLDU_NR_LANES-1:0]        result_be_o,
  input  wire logic    [`VLDU_NR_LANES-1:0]        result_gnt_i
);

  localparam int unsigned NrLanes = `VLDU_NR_LANES;
  localparam int unsigned Depth   = `VLDU_RESULT_DEPTH;
  localparam int unsigned PntW    = $clog2(Depth);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [PntW:0]   cnt_t;

  lane_result_t [NrLanes-1:0] entry_q [Depth];
  // Lanes of each entry still waiting for a grant
  logic [NrLanes-1:0] valid_q [Depth];

  pnt_t wr_pnt_q;
  pnt_t rd_pnt_q;
  cnt_t cnt_q;

  logic pop;
  logic [NrLanes-1:0] gnt;

  assign full_o = (cnt_q == cnt_t'(Depth));

  // Read entry is occupied but every lane has taken its part
  assign pop              = (cnt_q != '0) && (valid_q[rd_pnt_q] == '0);
  assign insn.word_popped = pop;

  // Grants count only for lanes still requesting
  assign gnt = result_gnt_i & valid_q[rd_pnt_q];

  //////////////////////////////////////////////////
  // Lane requests
  //////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k < NrLanes; k++) begin
      result_req_o[k]   = valid_q[rd_pnt_q][k];
      result_id_o[k]    = entry_q[rd_pnt_q][k].id;
      result_addr_o[k]  = entry_q[rd_pnt_q][k].addr;
      result_wdata_o[k] = entry_q[rd_pnt_q][k].data;
      result_be_o[k]    = entry_q[rd_pnt_q][k].be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int e = 0; e < Depth; e++) begin
        valid_q[e] <= '0;
      end
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int e = 0; e < Depth; e++) begin
        // Fresh word requests every lane, grants clear one lane each
        if (push_valid_i && (wr_pnt_q == pnt_t'(e))) begin
          valid_q[e] <= '1;
        end else if (rd_pnt_q == pnt_t'(e)) begin
          valid_q[e] <= valid_q[e] & ~gnt;
        end
      end
      if (push_valid_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_t'(push_valid_i) - cnt_t'(pop);
    end
  end

  // Word payload
  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      entry_q[wr_pnt_q] <= push_word_i;
    end
  end

endmodule
`default_nettype wire

// File: hw/vldu_top.sv
// Vector load unit top level
// Instruction queue, beat packer and result queue between the
// sequencer, the memory read channel and the lane write ports
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_top import vldu_pkg::*; (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  // Sequencer request
  input  wire logic                               req_valid_i,
  output logic                                    req_ready_o,
  input  wire vid_t                               req_id_i,
  input  wire vreg_t                              req_vd_i,
  input  wire vl_t                                req_vl_i,
  input  wire sew_e                               req_sew_i,
  // Memory read beats
  input  wire logic                               r_valid_i,
  input  wire lane_data_t                         r_data_i,
  output logic                                    r_ready_o,
  // Lane write ports
  output logic        [`VLDU_NR_LANES-1:0]        result_req_o,
  output vid_t        [`VLDU_NR_LANES-1:0]        result_id_o,
  output vaddr_t      [`VLDU_NR_LANES-1:0]        result_addr_o,
  output lane_data_t  [`VLDU_NR_LANES-1:0]        result_wdata_o,
  output lane_be_t    [`VLDU_NR_LANES-1:0]        result_be_o,
  input  wire logic   [`VLDU_NR_LANES-1:0]        result_gnt_i,
  // Completion report
  output logic                                    load_complete_o,
  output vid_t                                    done_id_o
);

  ldu_insn_t req_insn;
  logic      push_valid;
  logic      full;
  lane_result_t [`VLDU_NR_LANES-1:0] push_word;

  vldu_insn_if insn_if ();

  // Request fields as one queue entry
  assign req_insn = '{id: req_id_i, vd: req_vd_i, vl: req_vl_i, sew: req_sew_i};

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  vldu_insn_queue insn_queue_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_insn_i      (req_insn),
    .req_ready_o     (req_ready_o),
    .insn            (insn_if.insn_queue),
    .load_complete_o (load_complete_o),
    .done_id_o       (done_id_o)
  );

  vldu_beat_packer beat_packer_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_ready_o    (r_ready_o),
    .insn         (insn_if.packer),
    .full_i       (full),
    .push_valid_o (push_valid),
    .push_word_o  (push_word)
  );

  vldu_result_queue result_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_valid_i   (push_valid),
    .push_word_i    (push_word),
    .full_o         (full),
    .insn           (insn_if.result),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule
`default_nettype wire

// File: sim/vldu_sva.sv
// Vector load unit protocol checks
// Reset state, lane request stability, back-pressure and completion timing
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_sva import vldu_pkg::*; (
  input wire logic                              clk_i,
  input wire logic                              rst_ni,
  input wire logic                              req_ready_o,
  input wire logic                              r_ready_o,
  input wire logic                              push_valid,
  input wire logic                              load_complete_o,
  input wire logic       [`VLDU_NR_LANES-1:0]   result_req_o,
  input wire logic       [`VLDU_NR_LANES-1:0]   result_gnt_i,
  input wire vid_t       [`VLDU_NR_LANES-1:0]   result_id_o,
  input wire vaddr_t     [`VLDU_NR_LANES-1:0]   result_addr_o,
  input wire lane_data_t [`VLDU_NR_LANES-1:0]   result_wdata_o,
  input wire lane_be_t   [`VLDU_NR_LANES-1:0]   result_be_o
);

  // Result words in flight between packer push and pop
  logic [1:0] words_q;
  logic       word_pop;

  // A pop shows as an occupied queue with no lane request
  assign word_pop = (words_q != 2'd0) && (result_req_o == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      words_q <= 2'd0;
    end else begin
      words_q <= words_q + 2'(push_valid) - 2'(word_pop);
    end
  end

  // Idle outputs right after reset release
  assert property (@(posedge clk_i) $rose(rst_ni) |->
      req_ready_o && !r_ready_o && (result_req_o == '0) && !load_complete_o)
    else $error("outputs not idle after reset");

  // Memory is held while both result entries are taken
  assert property (@(posedge clk_i) disable iff (!rst_ni) (words_q == 2'd2) |-> !r_ready_o)
    else $error("r_ready_o high with a full result queue");

  //////////////////////////////////////////////////
  // Completion timing
  //////////////////////////////////////////////////

  // Pop cycle has no request and follows the grant that closed the word
  assert property (@(posedge clk_i) disable iff (!rst_ni) load_complete_o |->
      $past(result_req_o == '0) && $past(|(result_req_o & result_gnt_i), 2))
    else $error("completion not one cycle after a word pop");

  assert property (@(posedge clk_i) disable iff (!rst_ni) load_complete_o |=> !load_complete_o)
    else $error("completion pulse longer than one cycle");

  // Per-lane handshake
  for (genvar k = 0; k < `VLDU_NR_LANES; k++) begin : g_lane
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_req_o[k] && !result_gnt_i[k] |=> result_req_o[k] &&
        $stable(result_wdata_o[k]) && $stable(result_addr_o[k]) &&
        $stable(result_be_o[k]) && $stable(result_id_o[k]))
      else $error("lane %0d request or payload changed before grant", k);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_req_o[k] && result_gnt_i[k] |=> !result_req_o[k])
      else $error("lane %0d request still high after grant", k);
  end

endmodule

bind vldu_top vldu_sva sva_i (.*);
`default_nettype wire

// File: sim/vldu_tb.sv
// Vector load unit testbench
// Random loads, beats and grants against a scoreboard of expected lane words
`timescale 1ns/10ps
`default_nettype none
`include "vldu_consts.svh"

module vldu_tb import vldu_pkg::*; ();

  localparam int Lanes   = `VLDU_NR_LANES;
  localparam int Timeout = 4000;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic req_valid_i;
  logic req_ready_o;
  vid_t req_id_i;
  vreg_t req_vd_i;
  vl_t req_vl_i;
  sew_e req_sew_i;
  logic r_valid_i = 1'b0;
  lane_data_t r_data_i = '0;
  logic r_ready_o;
  logic [Lanes-1:0] result_req_o;
  vid_t [Lanes-1:0] result_id_o;
  vaddr_t [Lanes-1:0] result_addr_o;
  lane_data_t [Lanes-1:0] result_wdata_o;
  lane_be_t [Lanes-1:0] result_be_o;
  logic [Lanes-1:0] result_gnt_i = '0;
  logic load_complete_o;
  vid_t done_id_o;

  // Stimulus modes
  logic mem_en = 1'b1;
  logic stall_en = 1'b0;
  logic gnt_random = 1'b0;

  // Scoreboard
  lane_result_t [Lanes-1:0] exp_word [1024];
  int n_words = 0;
  int lane_idx [Lanes] = '{default: 0};
  lane_data_t beat_q [$];
  vid_t done_q [$];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int tests_failed = 0;
  int test_err0;
  logic [31:0] lcg_state = 32'hc671;
  vid_t next_id = '0;

  vldu_top dut_i (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("CHECK FAILED time %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    end
  endtask

  //////////////////////////////////////////////////
  // Expected words from the byte fill rules
  //////////////////////////////////////////////////

  task automatic record_insn(input ldu_insn_t ins);
    int nb;
    int nbeats;
    int nwords;
    int j;
    lane_data_t beats [$];
    lane_data_t d;
    nb = int'(ins.vl) << ins.sew;
    nbeats = (nb + 7) / 8;
    nwords = (nb + 31) / 32;
    for (int i = 0; i < nbeats; i++) begin
      d = {lcg_next(), lcg_next()};
      beats.push_back(d);
      beat_q.push_back(d);
    end
    for (int w = 0; w < nwords; w++) begin
      for (int k = 0; k < Lanes; k++) begin
        // Beat w*4+k lands in lane k of word w
        j = w * Lanes + k;
        exp_word[n_words][k].id = ins.id;
        exp_word[n_words][k].addr = vaddr_t'(int'(ins.vd) * `VLDU_REG_WORDS + w);
        exp_word[n_words][k].data = (j < nbeats) ? beats[j] : '0;
        for (int b = 0; b < 8; b++) begin
          exp_word[n_words][k].be[b] = (j * 8 + b < nb);
        end
      end
      n_words++;
    end
    done_q.push_back(ins.id);
  endtask

  task automatic send_insn(input vreg_t vd, input vl_t vl, input sew_e sew);
    int t;
    ldu_insn_t ins;
    ins = '{id: next_id, vd: vd, vl: vl, sew: sew};
    next_id = next_id + 1'b1;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_id_i <= ins.id;
    req_vd_i <= vd;
    req_vl_i <= vl;
    req_sew_i <= sew;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!req_ready_o && t < Timeout);
    req_valid_i <= 1'b0;
    if (!req_ready_o) begin
      errors++;
      $display("Timeout at %0t: load request was never accepted", $time);
    end else begin
      record_insn(ins);
    end
  endtask

  task automatic send_random_insn();
    logic [31:0] rnd;
    rnd = lcg_next();
    send_insn(vreg_t'(rnd[15:11]), vl_t'(1 + rnd[31:24] % 40), sew_e'(rnd[21:20]));
  endtask

  function automatic logic drained();
    logic ok;
    ok = (done_q.size() == 0) && (beat_q.size() == 0);
    for (int k = 0; k < Lanes; k++) begin
      ok = ok && (lane_idx[k] == n_words);
    end
    return ok;
  endfunction

  task automatic wait_drain();
    int t;
    t = 0;
    while (!drained() && t < Timeout) begin
      @(posedge clk_i);
      t++;
    end
    if (!drained()) begin
      errors++;
      $display("Timeout at %0t: outstanding loads did not drain", $time);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  //////////////////////////////////////////////////
  // Memory beats and lane grants
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : mem_drive
    logic [31:0] rnd;
    rnd = lcg_next();
    if (!rst_ni) begin
      r_valid_i <= 1'b0;
    end else begin
      if (r_valid_i && r_ready_o) begin
        void'(beat_q.pop_front());
      end
      if (mem_en && beat_q.size() != 0 && (!stall_en || rnd[31:30] != 2'd0)) begin
        r_valid_i <= 1'b1;
        r_data_i <= beat_q[0];
      end else begin
        r_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin : grant_drive
    logic [31:0] rnd;
    rnd = lcg_next();
    if (!rst_ni) begin
      result_gnt_i <= '0;
    end else if (gnt_random) begin
      result_gnt_i <= rnd[31:28];
    end else begin
      result_gnt_i <= '1;
    end
  end

  // Each granted lane write against the next expected word of that lane
  always @(posedge clk_i) begin : lane_check
    lane_result_t e;
    vid_t id;
    if (rst_ni) begin
      for (int k = 0; k < Lanes; k++) begin
        if (result_req_o[k] && result_gnt_i[k]) begin
          if (lane_idx[k] >= n_words) begin
            errors++;
            $display("Error at %0t: lane %0d wrote with no load pending", $time, k);
          end else begin
            e = exp_word[lane_idx[k]][k];
            check_value($sformatf("result_wdata_o[%0d]", k), e.data, result_wdata_o[k]);
            check_value($sformatf("result_be_o[%0d]", k), 64'(e.be), 64'(result_be_o[k]));
            check_value($sformatf("result_addr_o[%0d]", k), 64'(e.addr),
                        64'(result_addr_o[k]));
            check_value($sformatf("result_id_o[%0d]", k), 64'(e.id), 64'(result_id_o[k]));
            lane_idx[k]++;
          end
        end
      end
      if (load_complete_o) begin
        if (done_q.size() == 0) begin
          errors++;
          $display("Error at %0t: completion with no load pending", $time);
        end else begin
          id = done_q.pop_front();
          check_value("done_id_o", 64'(id), 64'(done_id_o));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    int t;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_id_i = '0;
    req_vd_i = '0;
    req_vl_i = '0;
    req_sew_i = EW8;
    test_err0 = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Full grants, memory always ready
    for (int i = 0; i < 6; i++) begin
      send_random_insn();
    end
    wait_drain();
    finish_test("byte order");

    // Tails inside a lane, inside a word and on a word edge
    send_insn(5'd1, 10'd1, EW8);
    send_insn(5'd2, 10'd33, EW8);
    send_insn(5'd31, 10'd5, EW64);
    send_insn(5'd7, 10'd3, EW16);
    send_insn(5'd9, 10'd8, EW32);
    wait_drain();
    finish_test("partial words and address");

    gnt_random = 1'b1;
    stall_en = 1'b1;
    for (int i = 0; i < 10; i++) begin
      send_random_insn();
    end
    wait_drain();
    gnt_random = 1'b0;
    stall_en = 1'b0;
    finish_test("back-pressure");

    // Memory held, so nothing commits
    mem_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_random_insn();
    end
    @(posedge clk_i);
    check_value("req_ready_o", 64'd0, 64'(req_ready_o));
    mem_en = 1'b1;
    t = 0;
    do begin
      @(posedge clk_i);
      t++;
    end while (!load_complete_o && t < Timeout);
    if (!load_complete_o) begin
      errors++;
      $display("Timeout at %0t: first load never completed", $time);
    end else begin
      check_value("req_ready_o", 64'd1, 64'(req_ready_o));
    end
    wait_drain();
    finish_test("queue limit");

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
`default_nettype wire

// File: src.f
+incdir+include
hw/vldu_pkg.sv
hw/vldu_insn_if.sv
hw/vldu_insn_queue.sv
hw/vldu_beat_packer.sv
hw/vldu_result_queue.sv
hw/vldu_top.sv
sim/vldu_sva.sv
sim/vldu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the vector load unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module vldu_tb -Mdir obj_dir -o vldu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/vldu_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^TEST OK$' <<< "$output"; then
  exit 0
fi
exit 1
